/* files.f */
+incdir+include
rtl/twiddle_pkg.sv
rtl/phase_divider.sv
rtl/cordic_rotator.sv
rtl/twiddle_core.sv
rtl/latency_timer.sv
rtl/wb_twiddle_ctrl.sv
rtl/twiddle_wb_top.sv
sim/tb_twiddle.sv

/* sim/tb_twiddle.sv */
//##########################################################################
// testbench for the twiddle generator, random bus traffic vs a real model
//##########################################################################
`timescale 1ns/1ps
`include "twiddle_defs.svh"

module tb_twiddle;

  localparam int n_rand = 200;
  localparam int n_wrap = 20;
  localparam int n_ops  = 2 * (n_rand + n_wrap) + 32;  // bus transfers, upper bound
  localparam real two_pi = 6.283185307179586;

  logic                  clk;
  logic                  reset;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  logic [`WB_ADDR_W-1:0] adr;
  logic [31:0]           dat_w;
  logic [31:0]           dat_r;
  logic                  ack;

  int          seed;
  int          acc_count;  // accepted writes seen by the testbench
  int          num;
  int          den;
  logic [31:0] rd;
  logic [31:0] res_before;

  twiddle_wb_top dut (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (n_ops * 60 + 200) @(posedge clk);
    $display("timeout: the bus did not finish all operations in time");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  task automatic check(input string name, input int got, input int expected, input int tol);
    longint diff;
    diff = longint'(got) - longint'(expected);
    if (diff < 0)
      diff = -diff;
    if (diff > tol) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, expected);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  // one classic transfer, ack sampled mid-cycle
  task automatic wb_write(input logic [`WB_ADDR_W-1:0] a, input logic [31:0] d);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    do @(negedge clk); while (!ack);
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    @(negedge clk);
    check("ack", ack, 0, 0);  // single-cycle ack
  endtask

  task automatic wb_read(input logic [`WB_ADDR_W-1:0] a, output logic [31:0] d);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    do @(negedge clk); while (!ack);
    d = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    @(negedge clk);
    check("ack", ack, 0, 0);
  endtask

  function automatic int round_real(input real x);
    if (x >= 0.0)
      return $rtoi(x + 0.5);
    return -$rtoi(-x + 0.5);
  endfunction

  // exp(-i 2pi n/d) scaled to 16384, angle wraps on whole turns
  task automatic model_coeff(input int n, input int d, output int re, output int im);
    real ang;
    ang = two_pi * real'(n % d) / real'(d);
    re  = round_real(16384.0 * $cos(ang));
    im  = round_real(-16384.0 * $sin(ang));
  endtask

  task automatic run_pair(input int n, input int d);
    logic [31:0] res;
    int          re;
    int          im;
    wb_write(0, {4'h0, d[11:0], 4'h0, n[11:0]});
    acc_count++;
    wb_read(1, res);
    model_coeff(n, d, re, im);
    check("result.re", $signed(res[15:0]), re, 4);
    check("result.im", $signed(res[31:16]), im, 4);
  endtask

  initial begin
    seed      = 48;
    acc_count = 0;
    reset <= 1'b1;
    cyc   <= 1'b0;
    stb   <= 1'b0;
    we    <= 1'b0;
    adr   <= '0;
    dat_w <= '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check("ack", ack, 0, 0);

    // registers come out of reset cleared
    for (int a = 0; a < 3; a++) begin
      wb_read(a, rd);
      check("dat_r after reset", rd, 0, 0);
    end

    for (int i = 0; i < n_rand; i++) begin
      den = 1 + ($unsigned($random(seed)) % 4095);
      num = $unsigned($random(seed)) % den;
      run_pair(num, den);
    end

    // num at or above den, wraps into the same turn
    for (int i = 0; i < n_wrap; i++) begin
      den = 1 + ($unsigned($random(seed)) % 2047);
      num = den + ($unsigned($random(seed)) % (4096 - den));
      run_pair(num, den);
    end

    wb_write(0, {4'h0, 12'd7, 4'h0, 12'd0});
    acc_count++;
    wb_read(1, rd);
    check("zero angle re", $signed(rd[15:0]), 16384, 4);
    check("zero angle im", $signed(rd[31:16]), 0, 4);
    wb_write(0, {4'h0, 12'd4, 4'h0, 12'd1});
    acc_count++;
    wb_read(1, rd);
    check("quarter turn re", $signed(rd[15:0]), 0, 4);
    check("quarter turn im", $signed(rd[31:16]), -16384, 4);

    // zero denominator is rejected, result kept
    wb_read(1, res_before);
    wb_write(0, {4'h0, 12'd0, 4'h0, 12'd123});
    wb_read(2, rd);
    check("status.zero_den", rd[0], 1, 0);
    check("status.count", rd[15:8], acc_count % 256, 0);
    wb_read(1, rd);
    check("result", rd, res_before, 0);
    wb_read(0, rd);
    check("operands", rd, {4'h0, 12'd0, 4'h0, 12'd123}, 0);

    run_pair(300, 1000);
    wb_read(2, rd);
    check("status.zero_den", rd[0], 0, 0);
    check("status.count", rd[15:8], acc_count % 256, 0);
    wb_read(0, rd);
    check("operands", rd, {4'h0, 12'd1000, 4'h0, 12'd300}, 0);

    // read-only words ignore writes
    wb_read(1, res_before);
    wb_write(1, 32'hdead_beef);
    wb_write(2, 32'hffff_ffff);
    wb_read(1, rd);
    check("result", rd, res_before, 0);
    wb_read(2, rd);
    check("status.zero_den", rd[0], 0, 0);
    check("status.count", rd[15:8], acc_count % 256, 0);
    wb_read(0, rd);
    check("operands", rd, {4'h0, 12'd1000, 4'h0, 12'd300}, 0);
    wb_read(5, rd);
    check("unmapped dat_r", rd, 0, 0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* rtl/twiddle_wb_top.sv */
//##########################################################################
// twiddle generator top, bus controller + latency timer + core
//##########################################################################
`timescale 1ns/1ps
`include "twiddle_defs.svh"

module twiddle_wb_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [`WB_ADDR_W-1:0]  adr,
  input  logic [31:0]            dat_w,
  output logic [31:0]            dat_r,
  output logic                   ack
);

  import twiddle_pkg::*;

  twiddle_req_t   req;
  twiddle_coeff_t coeff;
  logic           start;
  logic           done;
  logic           busy;

  wb_twiddle_ctrl u_ctrl (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .req   (req),
    .start (start),
    .done  (done),
    .busy  (busy),
    .coeff (coeff)
  );

  latency_timer u_timer (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .done  (done),
    .busy  (busy)
  );

  twiddle_core u_core (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .coeff (coeff)
  );

endmodule

/* rtl/wb_twiddle_ctrl.sv */
//##########################################################################
// Wishbone classic slave FSM, operand/result/status registers
//##########################################################################
`timescale 1ns/1ps
`include "twiddle_defs.svh"

module wb_twiddle_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         cyc,
  input  logic                         stb,
  input  logic                         we,
  input  logic [`WB_ADDR_W-1:0]        adr,
  input  logic [31:0]                  dat_w,
  output logic [31:0]                  dat_r,
  output logic                         ack,
  output twiddle_pkg::twiddle_req_t    req,
  output logic                         start,
  input  logic                         done,
  input  logic                         busy,
  input  twiddle_pkg::twiddle_coeff_t  coeff
);

  import twiddle_pkg::*;

  localparam int w_in    = `TWIDDLE_W_IN;
  localparam int den_lsb = 16;
  localparam logic [`WB_ADDR_W-1:0] adr_oper   = `WB_ADDR_W'(0);
  localparam logic [`WB_ADDR_W-1:0] adr_result = `WB_ADDR_W'(1);
  localparam logic [`WB_ADDR_W-1:0] adr_status = `WB_ADDR_W'(2);

  ctrl_state_e    state;
  twiddle_coeff_t result;
  twiddle_req_t   wr_req;
  logic           zero_den;   // sticky reject flag
  logic [7:0]     op_count;
  logic           wr_oper;

  assign wr_req  = '{den: dat_w[den_lsb +: w_in], num: dat_w[w_in-1:0]};
  assign wr_oper = cyc && stb && we && (adr == adr_oper);
  assign ack     = (state == ACK);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      start    <= 1'b0;
      req      <= '0;
      result   <= '0;
      zero_den <= 1'b0;
      op_count <= '0;
    end else begin
      start <= 1'b0;
      case (state)
        IDLE: begin
          if (wr_oper && wr_req.den == '0) begin  // rejected, core not started
            req      <= wr_req;
            zero_den <= 1'b1;
            state    <= ACK;
          end else if (wr_oper) begin
            if (!busy) begin
              req      <= wr_req;
              start    <= 1'b1;
              zero_den <= 1'b0;
              op_count <= op_count + 1'b1;
              state    <= RUN;
            end
          end else if (cyc && stb) begin
            state <= ACK;  // reads and ignored writes
          end
        end
        RUN: begin
          if (done) begin
            result <= coeff;
            state  <= ACK;
          end
        end
        default: state <= IDLE;  // ACK lasts one cycle
      endcase
    end
  end

  always_comb begin
    dat_r = '0;
    case (adr)
      adr_oper: begin
        dat_r[w_in-1:0]          = req.num;
        dat_r[den_lsb +: w_in]   = req.den;
      end
      adr_result: dat_r = result;
      adr_status: begin
        dat_r[0]    = zero_den;
        dat_r[15:8] = op_count;
      end
      default: dat_r = '0;
    endcase
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
    ack |-> cyc && stb);

  // timer done must find the FSM waiting on the core
  a_done_in_run: assert property (@(posedge clk) disable iff (reset)
    done |-> state == RUN);

endmodule

/* rtl/latency_timer.sv */
//##########################################################################
// latency down-counter, one done pulse per start
//##########################################################################
`timescale 1ns/1ps
`include "twiddle_defs.svh"

module latency_timer (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic done,
  output logic busy
);

  localparam int cnt_w = $clog2(`TWIDDLE_LATENCY + 1);

  logic [cnt_w-1:0] count;

  always_ff @(posedge clk) begin
    if (reset)
      count <= '0;
    else if (start && !busy)
      count <= cnt_w'(`TWIDDLE_LATENCY);
    else if (busy)
      count <= count - 1'b1;
  end

  assign busy = (count != '0);
  assign done = (count == cnt_w'(1));  // last cycle of the count

  // a start while counting would be lost
  a_start_not_busy: assert property (@(posedge clk) disable iff (reset)
    start |-> !busy);

endmodule

/* rtl/twiddle_core.sv */
//##########################################################################
// twiddle core, divider into rotator, output exp(-i*2pi*num/den)
//##########################################################################
`timescale 1ns/1ps
`include "twiddle_defs.svh"

module twiddle_core (
  input  logic                         clk,
  input  logic                         reset,
  input  twiddle_pkg::twiddle_req_t    req,
  output twiddle_pkg::twiddle_coeff_t  coeff
);

  import twiddle_pkg::*;

  phase_word_u                      phase;
  logic signed [`TWIDDLE_W_OUT-1:0] cos_val;
  logic signed [`TWIDDLE_W_OUT-1:0] sin_val;

  phase_divider u_div (
    .clk   (clk),
    .reset (reset),
    .num   (req.num),
    .den   (req.den),
    .phase (phase)
  );

  cordic_rotator u_rot (
    .clk     (clk),
    .reset   (reset),
    .phase   (phase),
    .cos_out (cos_val),
    .sin_out (sin_val)
  );

  // negative rotation direction
  always_comb begin
    coeff.re = cos_val;
    coeff.im = -sin_val;
  end

endmodule

/* rtl/cordic_rotator.sv */
//##########################################################################
// quadrant fold, pipelined CORDIC rotations and output rounding register
//##########################################################################
`timescale 1ns/1ps
`include "twiddle_defs.svh"

module cordic_rotator (
  input  logic                              clk,
  input  logic                              reset,
  input  twiddle_pkg::phase_word_u          phase,
  output logic signed [`TWIDDLE_W_OUT-1:0]  cos_out,
  output logic signed [`TWIDDLE_W_OUT-1:0]  sin_out
);

  localparam int n_iter = `CORDIC_ITER;
  localparam int guard  = 2;                          // extra low bits in x/y
  localparam int xy_w   = `TWIDDLE_W_OUT + guard + 2;
  localparam int z_w    = `TWIDDLE_PHASE_W;

  localparam logic signed [xy_w-1:0] x_start  = xy_w'(`CORDIC_X0 * (1 << guard));
  localparam logic signed [xy_w-1:0] rnd_bias = xy_w'(1 << (guard - 1));

  // atan(2^-i) in turns, 2^32 = full circle
  localparam logic signed [z_w-1:0] atan_table [0:n_iter-1] = '{
    32'h2000_0000, 32'h12E4_051D, 32'h09FB_385B, 32'h0511_11D4,
    32'h028B_0D43, 32'h0145_D7E1, 32'h00A2_F61E, 32'h0051_7C55,
    32'h0028_BE53, 32'h0014_5F2E, 32'h000A_2F98, 32'h0005_17CC,
    32'h0002_8BE6, 32'h0001_45F3, 32'h0000_A2F9, 32'h0000_517C
  };

  logic signed [xy_w-1:0] x_s [0:n_iter];
  logic signed [xy_w-1:0] y_s [0:n_iter];
  logic signed [z_w-1:0]  z_s [0:n_iter];
  logic signed [xy_w-1:0] x_rnd, y_rnd;

  // pre-rotate by the quadrant, residual stays below 90 deg
  always_ff @(posedge clk) begin
    if (reset) begin
      x_s[0] <= '0;
      y_s[0] <= '0;
      z_s[0] <= '0;
    end else begin
      case (phase.sector.quadrant)
        2'd0: begin x_s[0] <= x_start;  y_s[0] <= '0;       end
        2'd1: begin x_s[0] <= '0;       y_s[0] <= x_start;  end
        2'd2: begin x_s[0] <= -x_start; y_s[0] <= '0;       end
        default: begin x_s[0] <= '0;    y_s[0] <= -x_start; end
      endcase
      z_s[0] <= {2'b00, phase.sector.residual};
    end
  end

  for (genvar i = 0; i < n_iter; i++) begin : g_iter
    always_ff @(posedge clk) begin
      if (reset) begin
        x_s[i+1] <= '0;
        y_s[i+1] <= '0;
        z_s[i+1] <= '0;
      end else if (z_s[i][z_w-1]) begin  // overshot, rotate back
        x_s[i+1] <= x_s[i] + (y_s[i] >>> i);
        y_s[i+1] <= y_s[i] - (x_s[i] >>> i);
        z_s[i+1] <= z_s[i] + atan_table[i];
      end else begin
        x_s[i+1] <= x_s[i] - (y_s[i] >>> i);
        y_s[i+1] <= y_s[i] + (x_s[i] >>> i);
        z_s[i+1] <= z_s[i] - atan_table[i];
      end
    end
  end

  assign x_rnd = (x_s[n_iter] + rnd_bias) >>> guard;
  assign y_rnd = (y_s[n_iter] + rnd_bias) >>> guard;

  always_ff @(posedge clk) begin
    if (reset) begin
      cos_out <= '0;
      sin_out <= '0;
    end else begin
      cos_out <= x_rnd[`TWIDDLE_W_OUT-1:0];
      sin_out <= y_rnd[`TWIDDLE_W_OUT-1:0];
    end
  end

endmodule

/* rtl/phase_divider.sv */
//##########################################################################
// pipelined restoring divider, num/den as a rounded fraction of a turn
//##########################################################################
`timescale 1ns/1ps
`include "twiddle_defs.svh"

module phase_divider (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`TWIDDLE_W_IN-1:0]  num,
  input  logic [`TWIDDLE_W_IN-1:0]  den,
  output twiddle_pkg::phase_word_u  phase
);

  localparam int w_in    = `TWIDDLE_W_IN;
  localparam int n_stage = `TWIDDLE_PHASE_W;  // one quotient bit per stage

  logic [w_in-1:0]    rem_s [0:n_stage];
  logic [n_stage-1:0] quo_s [0:n_stage];
  logic [w_in-1:0]    den_s [0:n_stage];
  logic               round_up;

  // integer part of num/den is dropped, only num mod den matters
  function automatic logic [w_in-1:0] turn_reduce(input logic [w_in-1:0] n,
                                                  input logic [w_in-1:0] d);
    logic [w_in:0] r;
    r = '0;
    for (int i = w_in - 1; i >= 0; i--) begin
      r = {r[w_in-1:0], n[i]};
      if (r >= {1'b0, d})
        r = r - {1'b0, d};
    end
    return r[w_in-1:0];
  endfunction

  assign rem_s[0] = turn_reduce(num, den);
  assign quo_s[0] = '0;
  assign den_s[0] = den;

  for (genvar i = 0; i < n_stage; i++) begin : g_stage
    logic [w_in:0] trial;

    assign trial = {rem_s[i], 1'b0};  // low dividend bits are all zero

    always_ff @(posedge clk) begin
      if (reset) begin
        rem_s[i+1] <= '0;
        quo_s[i+1] <= '0;
        den_s[i+1] <= '0;
      end else begin
        den_s[i+1] <= den_s[i];
        if (trial >= {1'b0, den_s[i]}) begin
          rem_s[i+1] <= w_in'(trial - {1'b0, den_s[i]});
          quo_s[i+1] <= {quo_s[i][n_stage-2:0], 1'b1};
        end else begin
          rem_s[i+1] <= trial[w_in-1:0];
          quo_s[i+1] <= {quo_s[i][n_stage-2:0], 1'b0};
        end
      end
    end
  end

  // round on the final remainder
  assign round_up = rem_s[n_stage] > (den_s[n_stage] >> 1);

  always_ff @(posedge clk) begin
    if (reset)
      phase <= '0;
    else
      phase.turn <= quo_s[n_stage] + n_stage'(round_up);
  end

endmodule

/* rtl/twiddle_pkg.sv */
//##########################################################################
// operand and coefficient structs, phase word union, controller states
//##########################################################################
`include "twiddle_defs.svh"

package twiddle_pkg;

  // operand pair, controller -> core
  typedef struct packed {
    logic [`TWIDDLE_W_IN-1:0] den;
    logic [`TWIDDLE_W_IN-1:0] num;
  } twiddle_req_t;

  // same bit layout as the result read word (re low, im high)
  typedef struct packed {
    logic signed [`TWIDDLE_W_OUT-1:0] im;
    logic signed [`TWIDDLE_W_OUT-1:0] re;
  } twiddle_coeff_t;

  typedef struct packed {
    logic [1:0]                    quadrant;  // multiple of 90 deg
    logic [`TWIDDLE_PHASE_W-3:0]   residual;  // angle inside the quadrant
  } phase_sector_t;

  // divider writes turn, rotator reads sector
  typedef union packed {
    logic [`TWIDDLE_PHASE_W-1:0] turn;
    phase_sector_t               sector;
  } phase_word_u;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    ACK  = 2'd2
  } ctrl_state_e;

endpackage

/* include/twiddle_defs.svh */
//##########################################################################
// widths, pipeline latencies and CORDIC start value for the twiddle block
//##########################################################################
`ifndef TWIDDLE_DEFS_SVH
`define TWIDDLE_DEFS_SVH

`define TWIDDLE_W_IN     12   // numerator / denominator width
`define TWIDDLE_W_OUT    16   // re / im component width
`define TWIDDLE_PHASE_W  32   // fraction of a turn

// rotation stages in the CORDIC
`define CORDIC_ITER      16

`define DIV_LATENCY      33   // 32 quotient stages + rounding
`define CORDIC_LATENCY   18   // fold + 16 rotations + output reg
`define TWIDDLE_LATENCY  (`DIV_LATENCY + `CORDIC_LATENCY)

// 16384 / 1.6468, so the rotated amplitude lands on 16384
`define CORDIC_X0        9949

`define WB_ADDR_W        4    // word address

`endif
